// ==== src/memOpPkg.sv ====
/*
 * Memory operation semantics
 * Opcodes, environment codes, access sizes, execution states and the
 * misaligned access rule shared by both lanes
 */
package memOpPkg;

    localparam int AddrWidth = 32;

    typedef enum logic [2:0] {
        LOAD,
        ENV,
        FENCE_I,
        OTHER
    } memOpType;

    typedef enum logic [2:0] {
        BREAK,
        CALL,
        MRET,
        INSN_ILLEGAL,
        INSN_VIOLATION
    } envCode;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } accessSize;

    typedef enum logic [3:0] {
        NOT_FINISHED,
        SUCCESS,
        REFETCH_THIS,
        REFETCH_NEXT,
        TRAP_EBREAK,
        TRAP_ECALL,
        TRAP_MRET,
        FAULT_INSN_ILLEGAL,
        FAULT_INSN_VIOLATION,
        FAULT_LOAD_MISALIGNED,
        FAULT_LOAD_VIOLATION,
        FAULT_STORE_MISALIGNED,
        FAULT_STORE_VIOLATION
    } execState;

    // Natural alignment only, bytes never fault
    function automatic logic isMisaligned(logic [AddrWidth-1:0] addr, accessSize size);
        case (size)
            HALF:    return addr[0];
            WORD:    return |addr[1:0];
            default: return 1'b0;
        endcase
    endfunction

endpackage

// ==== src/stagePipePkg.sv ====
/*
 * Pipeline structure of the tag access stage
 * Active-list pointer, lane slot entry, lane result and credit width
 */
package stagePipePkg;

    import memOpPkg::*;

    localparam int PtrWidth    = 5;
    localparam int CreditWidth = 3;

    typedef logic [PtrWidth-1:0] activePtr;

    // Issued operation together with its lookup status
    typedef struct packed {
        memOpType               opType;
        envCode                 envCode;
        logic [AddrWidth-1:0]   addr;
        accessSize              size;
        logic                   mapIllegal;
        activePtr               activePtr;
        logic                   regValid;
        logic                   forwarded;
        logic                   forwardMiss;
        logic                   hasMshr;
        logic                   mshrHit;
        logic                   dcHit;
        logic                   conflict;
    } laneEntry;

    typedef struct packed {
        execState   execState;
        activePtr   activePtr;
        logic       replay;
        logic       orderViolation;
    } laneResult;

endpackage

// ==== src/laneIf.sv ====
/*
 * Link between the stage control and one lane resolver
 * Slot contents and update go out, the resolved result comes back
 */
`timescale 1ns/100ps

interface laneIf import stagePipePkg::*; (
    input logic clk
);

    laneEntry   entry;
    // Slot occupied and not hit by the flush
    logic       update;
    laneResult  result;

    modport ctrl (
        input  clk,
        output entry,
        output update,
        input  result
    );

    // Resolver is purely combinational over the slot
    modport resolver (
        input  clk,
        input  entry,
        input  update,
        output result
    );

endinterface

// ==== src/stageControl.sv ====
/*
 * Tag access stage control
 * One slot per lane with selective flush, downstream credit counters,
 * upstream credit return and the registered lane results
 */
`timescale 1ns/100ps

module stageControl import stagePipePkg::*; #(
    parameter int DownCredits = 2
) (
    input  logic      clk,
    input  logic      rstN,
    input  laneEntry  ldIn,
    input  logic      ldInValid,
    input  laneEntry  stIn,
    input  logic      stInValid,
    input  logic      flushValid,
    input  activePtr  flushHead,
    input  activePtr  flushTail,
    input  logic      ldCreditIn,
    input  logic      stCreditIn,
    laneIf.ctrl       ldLane,
    laneIf.ctrl       stLane,
    output logic      ldCreditOut,
    output logic      stCreditOut,
    output laneResult ldOut,
    output logic      ldOutValid,
    output laneResult stOut,
    output logic      stOutValid
);

    // Lane 0 is the load lane, lane 1 the store lane
    localparam int Lanes = 2;

    laneEntry               inEntry [Lanes];
    laneEntry               slot    [Lanes];
    laneResult              laneRes [Lanes];
    laneResult              outReg  [Lanes];
    logic [CreditWidth-1:0] downCnt [Lanes];
    logic [Lanes-1:0]       inValid;
    logic [Lanes-1:0]       creditIn;
    logic [Lanes-1:0]       slotValid;
    logic [Lanes-1:0]       flushHit;
    logic [Lanes-1:0]       update;
    logic [Lanes-1:0]       emit;
    logic [Lanes-1:0]       creditRet;
    logic [Lanes-1:0]       outValid;

    // Head inclusive, tail exclusive, wraps; head == tail covers everything
    function automatic logic inFlushRange(activePtr head, activePtr tail, activePtr ptr);
        if (head == tail) begin
            return 1'b1;
        end
        if (head < tail) begin
            return (ptr >= head) && (ptr < tail);
        end
        return (ptr >= head) || (ptr < tail);
    endfunction

    assign inEntry[0] = ldIn;
    assign inEntry[1] = stIn;
    assign inValid    = {stInValid, ldInValid};
    assign creditIn   = {stCreditIn, ldCreditIn};

    assign ldLane.entry  = slot[0];
    assign ldLane.update = update[0];
    assign stLane.entry  = slot[1];
    assign stLane.update = update[1];
    assign laneRes[0]    = ldLane.result;
    assign laneRes[1]    = stLane.result;

    always_comb begin
        for (int i = 0; i < Lanes; i++) begin
            flushHit[i] = slotValid[i] && flushValid
                          && inFlushRange(flushHead, flushTail, slot[i].activePtr);
            update[i]   = slotValid[i] && !flushHit[i];
            // Held in the slot until the lane has a downstream credit
            emit[i]     = update[i] && (downCnt[i] != '0);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < Lanes; i++) begin
            if (inValid[i]) begin
                slot[i] <= inEntry[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            slotValid <= '0;
            outValid  <= '0;
            creditRet <= '0;
            for (int i = 0; i < Lanes; i++) begin
                downCnt[i] <= CreditWidth'(DownCredits);
                outReg[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < Lanes; i++) begin
                if (inValid[i]) begin
                    slotValid[i] <= 1'b1;
                end else if (emit[i] || flushHit[i]) begin
                    slotValid[i] <= 1'b0;
                end
                downCnt[i] <= downCnt[i] - CreditWidth'(emit[i]) + CreditWidth'(creditIn[i]);
                if (emit[i]) begin
                    outReg[i] <= laneRes[i];
                end
            end
            outValid  <= emit;
            // Upstream credit comes back the cycle after the slot empties
            creditRet <= emit | flushHit;
        end
    end

    assign ldOut       = outReg[0];
    assign ldOutValid  = outValid[0];
    assign ldCreditOut = creditRet[0];
    assign stOut       = outReg[1];
    assign stOutValid  = outValid[1];
    assign stCreditOut = creditRet[1];

    for (genvar i = 0; i < Lanes; i++) begin : gLaneChk
        // Upstream must wait for its credit before sending again
        assert property (@(posedge clk) disable iff (!rstN)
            inValid[i] |-> !slotValid[i]);
        assert property (@(posedge clk) disable iff (!rstN)
            downCnt[i] <= CreditWidth'(DownCredits));
        assert property (@(posedge clk) disable iff (!rstN)
            $rose(outValid[i]) |-> $past(downCnt[i]) != '0);
    end

endmodule

// ==== src/loadResolver.sv ====
/*
 * Load lane resolver
 * Derives result validity from forwarding, MSHR and cache status, maps
 * ENV and FENCE.I to their states and applies the load fault checks
 */
`timescale 1ns/100ps

module loadResolver import memOpPkg::*, stagePipePkg::*; (
    laneIf.resolver lane
);

    laneEntry   op;
    logic       isLoad;
    logic       resValid;
    execState   state;

    assign op     = lane.entry;
    assign isLoad = (op.opType == LOAD);

    // Data source priority: forwarding, own MSHR, MSHR hit, then cache
    always_comb begin
        if (!isLoad) begin
            resValid = op.regValid;
        end else if (op.forwarded) begin
            resValid = !op.forwardMiss && op.regValid;
        end else if (op.hasMshr) begin
            resValid = op.mshrHit && op.regValid;
        end else if (op.mshrHit) begin
            resValid = op.regValid;
        end else begin
            resValid = op.dcHit && op.regValid;
        end
    end

    always_comb begin
        if (!lane.update || !resValid) begin
            state = NOT_FINISHED;
        end else begin
            case (op.opType)
                LOAD: state = SUCCESS;
                ENV: begin
                    case (op.envCode)
                        BREAK:          state = TRAP_EBREAK;
                        CALL:           state = TRAP_ECALL;
                        MRET:           state = TRAP_MRET;
                        INSN_ILLEGAL:   state = FAULT_INSN_ILLEGAL;
                        INSN_VIOLATION: state = FAULT_INSN_VIOLATION;
                        default:        state = TRAP_EBREAK;
                    endcase
                end
                // Later ops must not see stale ICache data
                FENCE_I: state = REFETCH_NEXT;
                default: state = SUCCESS;
            endcase
        end
        // Illegal map wins over misalignment
        if (isLoad && state == SUCCESS) begin
            if (op.mapIllegal) begin
                state = FAULT_LOAD_VIOLATION;
            end else if (isMisaligned(op.addr, op.size)) begin
                state = FAULT_LOAD_MISALIGNED;
            end
        end
    end

    always_comb begin
        lane.result.execState      = state;
        lane.result.activePtr      = op.activePtr;
        lane.result.replay         = lane.update && !resValid;
        lane.result.orderViolation = 1'b0;
    end

    // A replayed op never reaches the trap handler
    assert property (@(posedge lane.clk)
        lane.update && lane.result.replay
        |-> !(lane.result.execState inside {TRAP_EBREAK, TRAP_ECALL, TRAP_MRET}));

endmodule

// ==== src/storeResolver.sv ====
/*
 * Store lane resolver
 * Resolves the store state, flags memory order violations and raises
 * replay for stores without valid data
 */
`timescale 1ns/100ps

module storeResolver import memOpPkg::*, stagePipePkg::*; (
    laneIf.resolver lane
);

    laneEntry   op;
    logic       done;
    execState   state;

    assign op   = lane.entry;
    assign done = lane.update && op.regValid;

    always_comb begin
        if (!done) begin
            state = NOT_FINISHED;
        end else if (op.conflict) begin
            // Store itself is fine, restart from the next op
            state = REFETCH_NEXT;
        end else begin
            state = SUCCESS;
        end
        if (state inside {SUCCESS, REFETCH_NEXT}) begin
            if (op.mapIllegal) begin
                state = FAULT_STORE_VIOLATION;
            end else if (isMisaligned(op.addr, op.size)) begin
                state = FAULT_STORE_MISALIGNED;
            end
        end
    end

    always_comb begin
        lane.result.execState      = state;
        lane.result.activePtr      = op.activePtr;
        lane.result.replay         = lane.update && !op.regValid;
        // Still reported to the dependence predictor when a fault overrides
        lane.result.orderViolation = done && op.conflict;
    end

endmodule

// ==== src/tagAccessStage.sv ====
/*
 * Memory tag access stage, one load lane and one store lane
 * Packs the issued operations into slot entries and connects the
 * stage control to the two lane resolvers
 */
`timescale 1ns/100ps

module tagAccessStage import memOpPkg::*, stagePipePkg::*; #(
    parameter int DownCredits = 2
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 ldInValid,
    input  memOpType             ldOpType,
    input  envCode               ldEnvCode,
    input  logic [AddrWidth-1:0] ldAddr,
    input  accessSize            ldSize,
    input  logic                 ldMapIllegal,
    input  activePtr             ldActivePtr,
    input  logic                 ldRegValid,
    input  logic                 ldForwarded,
    input  logic                 ldForwardMiss,
    input  logic                 ldHasMshr,
    input  logic                 ldMshrHit,
    input  logic                 ldDcHit,
    input  logic                 stInValid,
    input  logic [AddrWidth-1:0] stAddr,
    input  accessSize            stSize,
    input  logic                 stMapIllegal,
    input  activePtr             stActivePtr,
    input  logic                 stRegValid,
    input  logic                 stConflict,
    input  logic                 flushValid,
    input  activePtr             flushHead,
    input  activePtr             flushTail,
    input  logic                 ldCreditIn,
    input  logic                 stCreditIn,
    output logic                 ldCreditOut,
    output logic                 stCreditOut,
    output logic                 ldOutValid,
    output execState             ldExecState,
    output activePtr             ldActivePtrOut,
    output logic                 ldReplay,
    output logic                 stOutValid,
    output execState             stExecState,
    output activePtr             stActivePtrOut,
    output logic                 stReplay,
    output logic                 orderViolation
);

    laneEntry   ldIn;
    laneEntry   stIn;
    laneResult  ldOut;
    laneResult  stOut;

    laneIf ldLane (.clk(clk));
    laneIf stLane (.clk(clk));

    always_comb begin
        ldIn             = '0;
        ldIn.opType      = ldOpType;
        ldIn.envCode     = ldEnvCode;
        ldIn.addr        = ldAddr;
        ldIn.size        = ldSize;
        ldIn.mapIllegal  = ldMapIllegal;
        ldIn.activePtr   = ldActivePtr;
        ldIn.regValid    = ldRegValid;
        ldIn.forwarded   = ldForwarded;
        ldIn.forwardMiss = ldForwardMiss;
        ldIn.hasMshr     = ldHasMshr;
        ldIn.mshrHit     = ldMshrHit;
        ldIn.dcHit       = ldDcHit;
    end

    // Store lane carries only the store fields
    always_comb begin
        stIn            = '0;
        stIn.addr       = stAddr;
        stIn.size       = stSize;
        stIn.mapIllegal = stMapIllegal;
        stIn.activePtr  = stActivePtr;
        stIn.regValid   = stRegValid;
        stIn.conflict   = stConflict;
    end

    stageControl #(
        .DownCredits(DownCredits)
    ) control (
        .clk        (clk),
        .rstN       (rstN),
        .ldIn       (ldIn),
        .ldInValid  (ldInValid),
        .stIn       (stIn),
        .stInValid  (stInValid),
        .flushValid (flushValid),
        .flushHead  (flushHead),
        .flushTail  (flushTail),
        .ldCreditIn (ldCreditIn),
        .stCreditIn (stCreditIn),
        .ldLane     (ldLane.ctrl),
        .stLane     (stLane.ctrl),
        .ldCreditOut(ldCreditOut),
        .stCreditOut(stCreditOut),
        .ldOut      (ldOut),
        .ldOutValid (ldOutValid),
        .stOut      (stOut),
        .stOutValid (stOutValid)
    );

    loadResolver ldResolver (.lane(ldLane.resolver));

    storeResolver stResolver (.lane(stLane.resolver));

    assign ldExecState    = ldOut.execState;
    assign ldActivePtrOut = ldOut.activePtr;
    assign ldReplay       = ldOut.replay;
    assign stExecState    = stOut.execState;
    assign stActivePtrOut = stOut.activePtr;
    assign stReplay       = stOut.replay;
    assign orderViolation = stOut.orderViolation;

endmodule

// ==== verif/tagAccessChecker.sv ====
/*
 * Tag access stage checker
 * Mirrors slot occupancy and downstream credits per lane, predicts each
 * result and compares it with the DUT outputs
 */
`timescale 1ns/100ps

module tagAccessChecker import memOpPkg::*, stagePipePkg::*; #(
    parameter int DownCredits = 2
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     ldInValid,
    input  laneEntry ldIn,
    input  logic     stInValid,
    input  laneEntry stIn,
    input  logic     flushValid,
    input  activePtr flushHead,
    input  activePtr flushTail,
    input  logic     ldCreditIn,
    input  logic     stCreditIn,
    input  logic     ldCreditOut,
    input  logic     stCreditOut,
    input  logic     ldOutValid,
    input  execState ldExecState,
    input  activePtr ldActivePtrOut,
    input  logic     ldReplay,
    input  logic     stOutValid,
    input  execState stExecState,
    input  activePtr stActivePtrOut,
    input  logic     stReplay,
    input  logic     orderViolation,
    output int       errorCount,
    output int       doneCount
);

    laneEntry   inEntry [2];
    laneResult  outRes  [2];
    logic [1:0] inValid;
    logic [1:0] outValid;
    logic [1:0] creditIn;
    logic [1:0] creditOut;
    // Ops waiting in the slot, and results due at the next edge
    laneEntry   pendQ   [2][$];
    laneResult  expQ    [2][$];
    int         downCnt [2];
    logic [1:0] creditDue;
    laneResult  want;
    string      pre;

    assign inEntry[0] = ldIn;
    assign inEntry[1] = stIn;
    assign outRes[0]  = {ldExecState, ldActivePtrOut, ldReplay, 1'b0};
    assign outRes[1]  = {stExecState, stActivePtrOut, stReplay, orderViolation};
    assign inValid    = {stInValid, ldInValid};
    assign outValid   = {stOutValid, ldOutValid};
    assign creditIn   = {stCreditIn, ldCreditIn};
    assign creditOut  = {stCreditOut, ldCreditOut};

    // Window starts at head and spans up to tail, modulo the pointer range
    function automatic bit inFlushWindow(activePtr head, activePtr tail, activePtr ptr);
        activePtr span;
        activePtr offset;
        span   = tail - head;
        offset = ptr - head;
        return (span == 0) || (offset < span);
    endfunction

    function automatic laneResult expectedResult(laneEntry e, bit storeLane);
        laneResult r;
        bit        valid;
        bit        misaligned;
        r           = '0;
        r.activePtr = e.activePtr;
        misaligned  = (e.size == HALF && e.addr[0]) || (e.size == WORD && e.addr[1:0] != 2'b00);
        if (storeLane) begin
            valid = e.regValid;
        end else if (e.opType != LOAD) begin
            valid = e.regValid;
        end else if (e.forwarded) begin
            valid = e.regValid && !e.forwardMiss;
        end else if (e.hasMshr) begin
            valid = e.regValid && e.mshrHit;
        end else begin
            valid = e.regValid && (e.mshrHit || e.dcHit);
        end
        r.replay = !valid;
        if (!valid) begin
            r.execState = NOT_FINISHED;
        end else if (storeLane) begin
            r.orderViolation = e.conflict;
            if (e.mapIllegal) begin
                r.execState = FAULT_STORE_VIOLATION;
            end else if (misaligned) begin
                r.execState = FAULT_STORE_MISALIGNED;
            end else begin
                r.execState = e.conflict ? REFETCH_NEXT : SUCCESS;
            end
        end else begin
            case (e.opType)
                LOAD: begin
                    if (e.mapIllegal) begin
                        r.execState = FAULT_LOAD_VIOLATION;
                    end else if (misaligned) begin
                        r.execState = FAULT_LOAD_MISALIGNED;
                    end else begin
                        r.execState = SUCCESS;
                    end
                end
                ENV: begin
                    case (e.envCode)
                        CALL:           r.execState = TRAP_ECALL;
                        MRET:           r.execState = TRAP_MRET;
                        INSN_ILLEGAL:   r.execState = FAULT_INSN_ILLEGAL;
                        INSN_VIOLATION: r.execState = FAULT_INSN_VIOLATION;
                        default:        r.execState = TRAP_EBREAK;
                    endcase
                end
                FENCE_I: r.execState = REFETCH_NEXT;
                default: r.execState = SUCCESS;
            endcase
        end
        return r;
    endfunction

    task automatic checkValue(string name, int expV, int actV);
        if (expV != actV) begin
            errorCount++;
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, expV, actV);
        end
    endtask

    // Outputs read here still hold the values registered at the previous edge
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2; i++) begin
                pendQ[i].delete();
                expQ[i].delete();
                downCnt[i]   = DownCredits;
                creditDue[i] = 1'b0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                pre = (i == 0) ? "ld" : "st";
                if (expQ[i].size() != 0) begin
                    want = expQ[i].pop_front();
                    checkValue({pre, "OutValid"}, 1, outValid[i]);
                    if (outValid[i]) begin
                        checkValue({pre, "ExecState"}, want.execState, outRes[i].execState);
                        checkValue({pre, "ActivePtrOut"}, want.activePtr, outRes[i].activePtr);
                        checkValue({pre, "Replay"}, want.replay, outRes[i].replay);
                        if (i == 1) begin
                            checkValue("orderViolation", want.orderViolation,
                                       outRes[i].orderViolation);
                        end
                    end
                    doneCount++;
                end else begin
                    checkValue({pre, "OutValid"}, 0, outValid[i]);
                end
                checkValue({pre, "CreditOut"}, creditDue[i], creditOut[i]);
                creditDue[i] = 1'b0;
                // Flush beats the emit, a slot without credit just waits
                if (pendQ[i].size() != 0) begin
                    if (flushValid && inFlushWindow(flushHead, flushTail, pendQ[i][0].activePtr)) begin
                        void'(pendQ[i].pop_front());
                        creditDue[i] = 1'b1;
                        doneCount++;
                    end else if (downCnt[i] > 0) begin
                        expQ[i].push_back(expectedResult(pendQ[i].pop_front(), i == 1));
                        downCnt[i]--;
                        creditDue[i] = 1'b1;
                    end
                end
                downCnt[i] += creditIn[i];
                if (inValid[i]) begin
                    if (pendQ[i].size() != 0) begin
                        errorCount++;
                        $display("%0t: %s lane got a new operation while its slot was full",
                                 $time, pre);
                    end
                    pendQ[i].push_back(inEntry[i]);
                end
            end
        end
    end

endmodule

// ==== verif/tagAccessTb.sv ====
/*
 * Tag access stage testbench
 * Random load and store traffic with upstream and downstream credit
 * keeping, random flushes and a cycle limit
 */
`timescale 1ns/100ps

module tagAccessTb import memOpPkg::*, stagePipePkg::*;;

    localparam int          DownCredits   = 2;
    localparam int          NumOps        = 400;
    localparam int          TimeoutCycles = NumOps * 20;
    localparam logic [31:0] Seed          = 32'h72a4dc23;

    logic     clk;
    logic     rstN;
    logic     ldInValid;
    logic     stInValid;
    laneEntry ldIn;
    laneEntry stIn;
    logic     flushValid;
    activePtr flushHead;
    activePtr flushTail;
    logic     ldCreditIn;
    logic     stCreditIn;
    logic     ldCreditOut;
    logic     stCreditOut;
    logic     ldOutValid;
    logic     stOutValid;
    execState ldExecState;
    execState stExecState;
    activePtr ldActivePtrOut;
    activePtr stActivePtrOut;
    logic     ldReplay;
    logic     stReplay;
    logic     orderViolation;
    int       errorCount;
    int       doneCount;
    int       cycles;
    int       sent;
    int       ldUp;
    int       stUp;
    int       ldOwed;
    int       stOwed;
    int       creditPct;

    tagAccessStage #(.DownCredits(DownCredits)) UUT (
        .clk           (clk),
        .rstN          (rstN),
        .ldInValid     (ldInValid),
        .ldOpType      (ldIn.opType),
        .ldEnvCode     (ldIn.envCode),
        .ldAddr        (ldIn.addr),
        .ldSize        (ldIn.size),
        .ldMapIllegal  (ldIn.mapIllegal),
        .ldActivePtr   (ldIn.activePtr),
        .ldRegValid    (ldIn.regValid),
        .ldForwarded   (ldIn.forwarded),
        .ldForwardMiss (ldIn.forwardMiss),
        .ldHasMshr     (ldIn.hasMshr),
        .ldMshrHit     (ldIn.mshrHit),
        .ldDcHit       (ldIn.dcHit),
        .stInValid     (stInValid),
        .stAddr        (stIn.addr),
        .stSize        (stIn.size),
        .stMapIllegal  (stIn.mapIllegal),
        .stActivePtr   (stIn.activePtr),
        .stRegValid    (stIn.regValid),
        .stConflict    (stIn.conflict),
        .flushValid    (flushValid),
        .flushHead     (flushHead),
        .flushTail     (flushTail),
        .ldCreditIn    (ldCreditIn),
        .stCreditIn    (stCreditIn),
        .ldCreditOut   (ldCreditOut),
        .stCreditOut   (stCreditOut),
        .ldOutValid    (ldOutValid),
        .ldExecState   (ldExecState),
        .ldActivePtrOut(ldActivePtrOut),
        .ldReplay      (ldReplay),
        .stOutValid    (stOutValid),
        .stExecState   (stExecState),
        .stActivePtrOut(stActivePtrOut),
        .stReplay      (stReplay),
        .orderViolation(orderViolation)
    );

    tagAccessChecker #(.DownCredits(DownCredits)) resultCheck (.*);

    // Mostly loads, with some ENV, FENCE.I and other ops mixed in
    function automatic laneEntry loadOp();
        laneEntry e;
        int       kind;
        e             = '0;
        kind          = $urandom_range(0, 7);
        e.opType      = (kind < 5) ? LOAD : memOpType'(kind - 4);
        e.envCode     = envCode'($urandom_range(0, 4));
        e.addr        = $urandom();
        e.size        = accessSize'($urandom_range(0, 2));
        e.mapIllegal  = ($urandom_range(0, 7) == 0);
        e.activePtr   = activePtr'($urandom_range(0, 31));
        e.regValid    = ($urandom_range(0, 7) != 0);
        e.forwarded   = $urandom_range(0, 1);
        e.forwardMiss = $urandom_range(0, 1);
        e.hasMshr     = $urandom_range(0, 1);
        e.mshrHit     = $urandom_range(0, 1);
        e.dcHit       = $urandom_range(0, 1);
        return e;
    endfunction

    function automatic laneEntry storeOp();
        laneEntry e;
        e            = '0;
        e.addr       = $urandom();
        e.size       = accessSize'($urandom_range(0, 2));
        e.mapIllegal = ($urandom_range(0, 7) == 0);
        e.activePtr  = activePtr'($urandom_range(0, 31));
        e.regValid   = ($urandom_range(0, 7) != 0);
        e.conflict   = ($urandom_range(0, 3) == 0);
        return e;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TimeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d operations finished",
                 cycles, doneCount, NumOps);
        $display("Closing: %0d operations checked, %0d errors", doneCount, errorCount);
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(Seed));
        rstN       = 1'b0;
        ldInValid  = 1'b0;
        stInValid  = 1'b0;
        ldIn       = '0;
        stIn       = '0;
        flushValid = 1'b0;
        flushHead  = '0;
        flushTail  = '0;
        ldCreditIn = 1'b0;
        stCreditIn = 1'b0;
        sent       = 0;
        ldUp       = 1;
        stUp       = 1;
        ldOwed     = 0;
        stOwed     = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        while (doneCount < NumOps) begin
            @(negedge clk);
            ldUp   += ldCreditOut;
            stUp   += stCreditOut;
            ldOwed += ldOutValid;
            stOwed += stOutValid;
            ldInValid = 1'b0;
            stInValid = 1'b0;
            if (sent < NumOps && ldUp > 0 && $urandom_range(0, 3) != 0) begin
                ldIn      = loadOp();
                ldInValid = 1'b1;
                ldUp--;
                sent++;
            end
            if (sent < NumOps && stUp > 0 && $urandom_range(0, 3) != 0) begin
                stIn      = storeOp();
                stInValid = 1'b1;
                stUp--;
                sent++;
            end
            flushValid = ($urandom_range(0, 9) == 0);
            flushHead  = activePtr'($urandom_range(0, 31));
            flushTail  = activePtr'($urandom_range(0, 31));
            // Downstream holds its credits back for a stretch every 200 cycles
            creditPct  = ((cycles % 200) >= 160) ? 0 : 40;
            ldCreditIn = (ldOwed > 0) && ($urandom_range(0, 99) < creditPct);
            stCreditIn = (stOwed > 0) && ($urandom_range(0, 99) < creditPct);
            ldOwed    -= ldCreditIn;
            stOwed    -= stCreditIn;
        end
        // Let the last credit return be checked
        repeat (2) @(posedge clk);
        $display("Closing: %0d operations checked, %0d errors", doneCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tagAccessStage.f ====
src/memOpPkg.sv
src/stagePipePkg.sv
src/laneIf.sv
src/stageControl.sv
src/loadResolver.sv
src/storeResolver.sv
src/tagAccessStage.sv
verif/tagAccessChecker.sv
verif/tagAccessTb.sv
